// ==== design/per_bus_pkg.sv ====
/*
 * Peripheral bus package
 *   Bus widths for address, data and byte write enable
 *   Byte base addresses of the two digital I/O ports
 *   Register byte offsets within a port, Timer A register addresses
 *   Decoded word address union (raw word or block/slot fields)
 */
`default_nettype none

package per_bus_pkg;

  // ====================
  // Bus widths
  // ====================
  localparam int PER_AW  = 14;                   // Word address
  localparam int PER_DW  = 16;                   // Data
  localparam int PER_WEW = 2;                    // One enable per byte lane

  // ====================
  // Address map
  // ====================
  localparam logic [15:0] P1_BASE = 16'h0020;    // Port 1 byte base
  localparam logic [15:0] P2_BASE = 16'h0028;    // Port 2 byte base

  localparam int GPIO_IN  = 0;                   // Synchronized input, read only
  localparam int GPIO_OUT = 1;                   // Output data
  localparam int GPIO_DIR = 2;                   // Direction, 1 = output
  localparam int GPIO_IFG = 3;                   // Interrupt flags
  localparam int GPIO_IES = 4;                   // Edge select, 1 = falling
  localparam int GPIO_IE  = 5;                   // Interrupt enables
  localparam int GPIO_SEL = 6;                   // Function select

  localparam logic [15:0] TA_TACTL   = 16'h0160; // Timer control
  localparam logic [15:0] TA_TACCTL0 = 16'h0162; // Compare 0 control
  localparam logic [15:0] TA_TAR     = 16'h0170; // Counter
  localparam logic [15:0] TA_TACCR0  = 16'h0172; // Compare 0 value

  // Word address seen as 32-byte block plus word slot
  typedef struct packed {
    logic [9:0] blk;                             // Peripheral block index
    logic [3:0] slot;                            // Register word in block
  } per_field_t;

  typedef union packed {
    logic [PER_AW-1:0] word;                     // Raw word address
    per_field_t        f;                        // Block/slot view
  } per_addr_t;

endpackage

`default_nettype wire

// ==== design/irq_pkg.sv ====
/*
 * Interrupt package
 *   Width of the maskable interrupt vector bus
 *   Vector index of each kept interrupt source
 */
`default_nettype none

package irq_pkg;

  // ====================
  // Vector bus
  // ====================
  localparam int IRQ_W = 14;       // Maskable vectors 0 to 13

  // Source positions, higher index = higher priority
  localparam int IRQ_TA0   = 9;    // Timer A compare 0
  localparam int IRQ_TA1   = 8;    // Timer A overflow
  localparam int IRQ_PORT2 = 3;    // Port 2 edge
  localparam int IRQ_PORT1 = 2;    // Port 1 edge

  // Vectors 0, 1, 4 to 7 and 10 to 13 have no source here

endpackage

`default_nettype wire

// ==== design/gpio_port.sv ====
/*
 * One 8-bit digital I/O port
 *   Address decode against the port byte base
 *   OUT, DIR, IFG, IES, IE and SEL registers
 *   Two-stage input synchronizer and edge detector
 *   Edge interrupt flags and the port interrupt
 */
`default_nettype none

module gpio_port #(
  parameter logic [15:0] PORT_BASE = per_bus_pkg::P1_BASE    // Byte base address
) (
  input  logic                               mclk,
  input  logic                               rst,
  input  per_bus_pkg::per_addr_t             per_addr,
  input  logic [per_bus_pkg::PER_DW-1:0]     per_din,
  input  logic [per_bus_pkg::PER_WEW-1:0]    per_we,
  input  logic                               per_en,
  output logic [per_bus_pkg::PER_DW-1:0]     per_dout,
  input  logic [7:0]                         p_din,          // Pad inputs
  output logic [7:0]                         p_dout,         // Pad outputs
  output logic [7:0]                         p_dout_en,      // Pad output enables
  output logic [7:0]                         p_sel,          // Function select
  output logic                               irq_port        // Level interrupt
);

  localparam int NREG = 7;                                   // Byte offsets 0 to 6

  // ====================
  // Address decode
  // ====================
  logic            port_sel;
  logic [1:0]      word_idx;
  logic [NREG-1:0] reg_wr;
  logic [NREG-1:0] reg_rd;
  logic [7:0]      wr_data [NREG];
  logic [7:0]      rd_val  [NREG];

  // Both ports share one block, the upper slot bits split them
  assign port_sel = per_en & (per_addr.f.blk == PORT_BASE[14:5])
                           & (per_addr.f.slot[3:2] == PORT_BASE[4:3]);
  assign word_idx = per_addr.f.slot[1:0];                    // Word within port

  always_comb begin
    for (int k = 0; k < NREG; k++) begin
      reg_wr[k]  = port_sel & per_we[k % 2] & (word_idx == 2'(k / 2));  // Lane write
      reg_rd[k]  = port_sel & ~|per_we & (word_idx == 2'(k / 2));        // Read strobe
      wr_data[k] = (k % 2 == 1) ? per_din[15:8] : per_din[7:0];          // Odd = lane 1
    end
  end

  // ====================
  // Input synchronizer
  // ====================
  logic [7:0] din_s1;                                        // First stage
  logic [7:0] din_s2;                                        // GPIO_IN value
  logic [7:0] din_dly;                                       // For edge detect
  logic [7:0] edge_set;

  always_ff @(posedge mclk) begin
    if (rst) begin
      din_s1  <= '0;
      din_s2  <= '0;
      din_dly <= '0;
    end else begin
      din_s1  <= p_din;
      din_s2  <= din_s1;
      din_dly <= din_s2;
    end
  end

  // ====================
  // Control registers
  // ====================
  logic [7:0] p_out;
  logic [7:0] p_dir;
  logic [7:0] p_ifg;
  logic [7:0] p_ies;
  logic [7:0] p_ie;
  logic [7:0] p_fsel;
  logic [7:0] ifg_nxt;

  // Rising edge when IES is 0, falling edge when IES is 1
  assign edge_set = (din_s2 & ~din_dly & ~p_ies) | (~din_s2 & din_dly & p_ies);

  // Edge set wins over a write clear
  assign ifg_nxt = (reg_wr[per_bus_pkg::GPIO_IFG] ? wr_data[per_bus_pkg::GPIO_IFG] : p_ifg)
                 | edge_set;

  always_ff @(posedge mclk) begin
    if (rst) begin
      p_out  <= '0;
      p_dir  <= '0;
      p_ifg  <= '0;
      p_ies  <= '0;
      p_ie   <= '0;
      p_fsel <= '0;
    end else begin
      if (reg_wr[per_bus_pkg::GPIO_OUT]) p_out  <= wr_data[per_bus_pkg::GPIO_OUT];
      if (reg_wr[per_bus_pkg::GPIO_DIR]) p_dir  <= wr_data[per_bus_pkg::GPIO_DIR];
      if (reg_wr[per_bus_pkg::GPIO_IES]) p_ies  <= wr_data[per_bus_pkg::GPIO_IES];
      if (reg_wr[per_bus_pkg::GPIO_IE])  p_ie   <= wr_data[per_bus_pkg::GPIO_IE];
      if (reg_wr[per_bus_pkg::GPIO_SEL]) p_fsel <= wr_data[per_bus_pkg::GPIO_SEL];
      p_ifg <= ifg_nxt;                                      // Flags update every cycle
    end
  end

  // ====================
  // Read back and outputs
  // ====================
  assign rd_val[per_bus_pkg::GPIO_IN]  = din_s2;
  assign rd_val[per_bus_pkg::GPIO_OUT] = p_out;
  assign rd_val[per_bus_pkg::GPIO_DIR] = p_dir;
  assign rd_val[per_bus_pkg::GPIO_IFG] = p_ifg;
  assign rd_val[per_bus_pkg::GPIO_IES] = p_ies;
  assign rd_val[per_bus_pkg::GPIO_IE]  = p_ie;
  assign rd_val[per_bus_pkg::GPIO_SEL] = p_fsel;

  always_comb begin
    per_dout = '0;                                           // Zero when idle for OR bus
    for (int k = 0; k < NREG; k++) begin
      if (reg_rd[k]) begin
        if (k % 2 == 1) per_dout[15:8] = rd_val[k];          // Odd byte, lane 1
        else            per_dout[7:0]  = rd_val[k];
      end
    end
  end

  assign p_dout    = p_out;
  assign p_dout_en = p_dir;
  assign p_sel     = p_fsel;
  assign irq_port  = |(p_ifg & p_ie);                        // Any enabled flag

endmodule

`default_nettype wire

// ==== design/timer_a.sv ====
/*
 * Reduced Timer A
 *   TACTL, TACCTL0, TAR and TACCR0 registers
 *   Clock source select and input divider
 *   Up mode and continuous mode counter
 *   Compare 0 and overflow interrupts
 */
`default_nettype none

module timer_a (
  input  logic                               mclk,
  input  logic                               rst,
  input  per_bus_pkg::per_addr_t             per_addr,
  input  logic [per_bus_pkg::PER_DW-1:0]     per_din,
  input  logic [per_bus_pkg::PER_WEW-1:0]    per_we,
  input  logic                               per_en,
  output logic [per_bus_pkg::PER_DW-1:0]     per_dout,
  input  logic                               aclk_en,        // ACLK enable
  input  logic                               smclk_en,       // SMCLK enable
  input  logic                               irq_ta0_acc,    // Compare 0 vector taken
  output logic                               irq_ta0,
  output logic                               irq_ta1
);

  localparam logic [9:0] TA_BLK       = per_bus_pkg::TA_TACTL[14:5];
  localparam logic [3:0] SLOT_TACTL   = per_bus_pkg::TA_TACTL[4:1];
  localparam logic [3:0] SLOT_TACCTL0 = per_bus_pkg::TA_TACCTL0[4:1];
  localparam logic [3:0] SLOT_TAR     = per_bus_pkg::TA_TAR[4:1];
  localparam logic [3:0] SLOT_TACCR0  = per_bus_pkg::TA_TACCR0[4:1];

  // ====================
  // Address decode
  // ====================
  logic ta_sel;
  logic ta_wr;
  logic ta_rd;
  logic tactl_wr;
  logic tacctl0_wr;
  logic tar_wr;
  logic taccr0_wr;
  logic taclr;

  assign ta_sel     = per_en & (per_addr.f.blk == TA_BLK);
  assign ta_wr      = ta_sel & |per_we;                      // Word registers
  assign ta_rd      = ta_sel & ~|per_we;
  assign tactl_wr   = ta_wr & (per_addr.f.slot == SLOT_TACTL);
  assign tacctl0_wr = ta_wr & (per_addr.f.slot == SLOT_TACCTL0);
  assign tar_wr     = ta_wr & (per_addr.f.slot == SLOT_TAR);
  assign taccr0_wr  = ta_wr & (per_addr.f.slot == SLOT_TACCR0);
  assign taclr      = tactl_wr & per_din[2];                 // Self-clearing

  // ====================
  // Registers
  // ====================
  logic [1:0]  tassel;
  logic [1:0]  id;
  logic [1:0]  mc;
  logic        taie;
  logic        taifg;
  logic        ccie;
  logic        ccifg;
  logic [15:0] tar;
  logic [15:0] taccr0;
  logic [2:0]  clk_div;
  logic        taifg_set;
  logic        ccifg_set;

  always_ff @(posedge mclk) begin
    if (rst) begin
      tassel <= '0;
      id     <= '0;
      mc     <= '0;
      taie   <= 1'b0;
      taifg  <= 1'b0;
      ccie   <= 1'b0;
      ccifg  <= 1'b0;
      taccr0 <= '0;
    end else begin
      if (tactl_wr) begin
        tassel <= per_din[9:8];
        id     <= per_din[7:6];
        mc     <= per_din[5:4];
        taie   <= per_din[1];
      end
      if (tacctl0_wr) ccie   <= per_din[4];
      if (taccr0_wr)  taccr0 <= per_din;
      if (taifg_set)     taifg <= 1'b1;                      // Only a write clears it
      else if (tactl_wr) taifg <= per_din[0];
      if (ccifg_set)        ccifg <= 1'b1;
      else if (irq_ta0_acc) ccifg <= 1'b0;                   // Vector taken
      else if (tacctl0_wr)  ccifg <= per_din[0];
    end
  end

  // ====================
  // Clock and counter
  // ====================
  logic        sel_clk;
  logic        cnt_mode;
  logic        div_ok;
  logic        tar_tick;
  logic        tar_wrap;
  logic [15:0] tar_nxt;

  // TACLK and INCLK are tied off, only ACLK and SMCLK tick
  assign sel_clk  = (tassel == 2'b01) ? aclk_en :
                    (tassel == 2'b10) ? smclk_en : 1'b0;
  assign cnt_mode = (mc == 2'b01) | (mc == 2'b10);          // Up or continuous

  always_comb begin
    case (id)
      2'b00:   div_ok = 1'b1;                                // /1
      2'b01:   div_ok = clk_div[0];                          // /2
      2'b10:   div_ok = &clk_div[1:0];                       // /4
      default: div_ok = &clk_div;                            // /8
    endcase
  end

  assign tar_tick  = sel_clk & div_ok & cnt_mode;
  // Up mode also rolls over if TACCR0 was moved below TAR
  assign tar_wrap  = (mc == 2'b01) ? (tar >= taccr0) : (tar == 16'hFFFF);
  assign tar_nxt   = tar_wrap ? '0 : tar + 16'd1;
  assign ccifg_set = tar_tick & (tar_nxt == taccr0);         // TAR reaches TACCR0
  assign taifg_set = tar_tick & tar_wrap;                    // Rollover to zero

  always_ff @(posedge mclk) begin
    if (rst || taclr) begin
      clk_div <= '0;
      tar     <= '0;
    end else begin
      if (sel_clk && cnt_mode) clk_div <= clk_div + 3'd1;
      if (tar_wr)        tar <= per_din;
      else if (tar_tick) tar <= tar_nxt;
    end
  end

  // ====================
  // Read back and interrupts
  // ====================
  always_comb begin
    per_dout = '0;
    if (ta_rd) begin
      case (per_addr.f.slot)
        SLOT_TACTL:   per_dout = {6'b0, tassel, id, mc, 2'b00, taie, taifg};  // TACLR reads 0
        SLOT_TACCTL0: per_dout = {11'b0, ccie, 3'b000, ccifg};
        SLOT_TAR:     per_dout = tar;
        SLOT_TACCR0:  per_dout = taccr0;
        default:      per_dout = '0;
      endcase
    end
  end

  assign irq_ta0 = ccie & ccifg;
  assign irq_ta1 = taie & taifg;

endmodule

`default_nettype wire

// ==== design/periph_core0.sv ====
/*
 * Peripheral subsystem top level
 *   Port 1 on the switches, port 2 on the LEDs
 *   Timer A with its compare 0 accept
 *   OR of the peripheral read data, interrupt vector packing
 */
`default_nettype none

module periph_core0 (
  input  logic                               mclk,
  input  logic                               rst,
  input  logic [per_bus_pkg::PER_AW-1:0]     per_addr,       // Word address
  input  logic [per_bus_pkg::PER_DW-1:0]     per_din,
  input  logic [per_bus_pkg::PER_WEW-1:0]    per_we,
  input  logic                               per_en,
  output logic [per_bus_pkg::PER_DW-1:0]     per_dout,
  input  logic                               aclk_en,
  input  logic                               smclk_en,
  input  logic [irq_pkg::IRQ_W-1:0]          irq_acc,        // One-hot accept
  output logic [irq_pkg::IRQ_W-1:0]          irq_bus,
  input  logic [3:0]                         switch,
  output logic [1:0]                         led
);

  logic [per_bus_pkg::PER_DW-1:0] per_dout_p1;
  logic [per_bus_pkg::PER_DW-1:0] per_dout_p2;
  logic [per_bus_pkg::PER_DW-1:0] per_dout_ta;
  logic                           irq_port1;
  logic                           irq_port2;
  logic                           irq_ta0;
  logic                           irq_ta1;
  logic [7:0]                     p1_din;
  logic [7:0]                     p2_dout;
  logic [7:0]                     p2_dout_en;

  assign p1_din = {4'h0, switch};                            // Upper pins unused

  // ====================
  // Peripherals
  // ====================
  gpio_port #(.PORT_BASE(per_bus_pkg::P1_BASE)) gpio_p1 (
    .mclk      (mclk),
    .rst       (rst),
    .per_addr  (per_addr),
    .per_din   (per_din),
    .per_we    (per_we),
    .per_en    (per_en),
    .per_dout  (per_dout_p1),
    .p_din     (p1_din),
    .p_dout    (),                                           // No pads driven
    .p_dout_en (),
    .p_sel     (),
    .irq_port  (irq_port1)
  );

  gpio_port #(.PORT_BASE(per_bus_pkg::P2_BASE)) gpio_p2 (
    .mclk      (mclk),
    .rst       (rst),
    .per_addr  (per_addr),
    .per_din   (per_din),
    .per_we    (per_we),
    .per_en    (per_en),
    .per_dout  (per_dout_p2),
    .p_din     (8'h00),                                      // Output only
    .p_dout    (p2_dout),
    .p_dout_en (p2_dout_en),
    .p_sel     (),
    .irq_port  (irq_port2)
  );

  timer_a ta_0 (
    .mclk        (mclk),
    .rst         (rst),
    .per_addr    (per_addr),
    .per_din     (per_din),
    .per_we      (per_we),
    .per_en      (per_en),
    .per_dout    (per_dout_ta),
    .aclk_en     (aclk_en),
    .smclk_en    (smclk_en),
    .irq_ta0_acc (irq_acc[irq_pkg::IRQ_TA0]),                // Clears CCIFG
    .irq_ta0     (irq_ta0),
    .irq_ta1     (irq_ta1)
  );

  // ====================
  // Glue
  // ====================
  assign per_dout = per_dout_p1 | per_dout_p2 | per_dout_ta; // Idle slaves drive zero
  assign led      = p2_dout[1:0] & p2_dout_en[1:0];          // Lit only when output

  always_comb begin
    irq_bus                     = '0;
    irq_bus[irq_pkg::IRQ_TA0]   = irq_ta0;
    irq_bus[irq_pkg::IRQ_TA1]   = irq_ta1;
    irq_bus[irq_pkg::IRQ_PORT2] = irq_port2;
    irq_bus[irq_pkg::IRQ_PORT1] = irq_port1;
  end

endmodule

`default_nettype wire

// ==== verification/periph_core0_props.sv ====
/*
 * Bound checks on the subsystem top level
 *   Read data idle while the bus is idle
 *   Vector bits without a source stay low
 *   LEDs and vectors cleared by reset
 */
`default_nettype none

module periph_core0_props (
  input logic                           mclk,
  input logic                           rst,
  input logic                           per_en,
  input logic [per_bus_pkg::PER_DW-1:0] per_dout,
  input logic [irq_pkg::IRQ_W-1:0]      irq_bus,
  input logic [1:0]                     led
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [irq_pkg::IRQ_W-1:0] IRQ_BIT0 = {{(irq_pkg::IRQ_W-1){1'b0}}, 1'b1};

  // Vectors with a source
  localparam logic [irq_pkg::IRQ_W-1:0] IRQ_USED = (IRQ_BIT0 << irq_pkg::IRQ_TA0)
                                                 | (IRQ_BIT0 << irq_pkg::IRQ_TA1)
                                                 | (IRQ_BIT0 << irq_pkg::IRQ_PORT2)
                                                 | (IRQ_BIT0 << irq_pkg::IRQ_PORT1);

  int fail_cnt;                                 // Property failures so far

  // ====================
  // Properties
  // ====================
  idle_dout: assert property (@(posedge mclk) !per_en |-> per_dout == '0)
    else begin
      $error("per_dout not zero with per_en low");
      fail_cnt++;
    end

  unused_irq: assert property (@(posedge mclk) disable iff (rst) (irq_bus & ~IRQ_USED) == '0)
    else begin
      $error("irq_bus bit without a source is set");
      fail_cnt++;
    end

  reset_state: assert property (@(posedge mclk) rst |=> (led == '0) && (irq_bus == '0))
    else begin
      $error("led or irq_bus not cleared by reset");
      fail_cnt++;
    end

endmodule

bind periph_core0 periph_core0_props props_0 (
  .mclk     (mclk),
  .rst      (rst),
  .per_en   (per_en),
  .per_dout (per_dout),
  .irq_bus  (irq_bus),
  .led      (led)
);

`default_nettype wire

// ==== verification/periph_core0_tb.sv ====
/*
 * Testbench for the peripheral subsystem
 *   Clock, reset and cycle-count timeout
 *   Bus write and read tasks, stimulus table
 *   Switch, LED, port interrupt, Timer A and clock gating checks
 */
`default_nettype none

module periph_core0_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [15:0] P1 = per_bus_pkg::P1_BASE;
  localparam logic [15:0] P2 = per_bus_pkg::P2_BASE;

  typedef struct packed {
    logic        rd;                                  // 1 = read and compare
    logic [15:0] addr;                                // Byte address
    logic [1:0]  we;
    logic [15:0] data;
    logic [15:0] exp;
    logic [15:0] mask;
  } step_t;

  logic                            mclk;
  logic                            rst;
  logic [per_bus_pkg::PER_AW-1:0]  per_addr;
  logic [per_bus_pkg::PER_DW-1:0]  per_din;
  logic [per_bus_pkg::PER_WEW-1:0] per_we;
  logic                            per_en;
  logic [per_bus_pkg::PER_DW-1:0]  per_dout;
  logic                            aclk_en;
  logic                            smclk_en;
  logic [irq_pkg::IRQ_W-1:0]       irq_acc;
  logic [irq_pkg::IRQ_W-1:0]       irq_bus;
  logic [3:0]                      switch;
  logic [1:0]                      led;

  step_t      steps [$];
  logic [7:0] led_out;                                // Model of P2OUT
  logic [7:0] led_dir;                                // Model of P2DIR
  int         cycle_cnt;
  int         cycle_limit;

  periph_core0 uut (
    .mclk     (mclk),
    .rst      (rst),
    .per_addr (per_addr),
    .per_din  (per_din),
    .per_we   (per_we),
    .per_en   (per_en),
    .per_dout (per_dout),
    .aclk_en  (aclk_en),
    .smclk_en (smclk_en),
    .irq_acc  (irq_acc),
    .irq_bus  (irq_bus),
    .switch   (switch),
    .led      (led)
  );

  initial begin
    mclk = 1'b0;
    forever #20 mclk = ~mclk;                         // 40 ns period
  end

  // ====================
  // Helpers
  // ====================
  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "Run stopped at first failure");
  endtask

  always @(posedge mclk) begin
    cycle_cnt++;
    if (uut.props_0.fail_cnt != 0)
      report_fail("A bound property on the top-level ports failed");
    else if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
      report_fail($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
  end

  function automatic logic [15:0] port_reg(input logic [15:0] base, input int off);
    return base + 16'(off);
  endfunction

  function automatic void write_step(input logic [15:0] addr, input logic [1:0] we,
                                     input logic [15:0] data);
    steps.push_back({1'b0, addr, we, data, 16'h0000, 16'h0000});
  endfunction

  function automatic void read_step(input logic [15:0] addr, input logic [15:0] exp,
                                    input logic [15:0] mask);
    steps.push_back({1'b1, addr, 2'b00, 16'h0000, exp, mask});
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge mclk);
      #2;
    end
  endtask

  // Called 2 ns after an edge and returns 2 ns after the write edge
  task automatic write_reg(input logic [15:0] addr, input logic [1:0] we,
                           input logic [15:0] data);
    per_addr = addr[14:1];                            // Word address
    per_din  = data;
    per_we   = we;
    per_en   = 1'b1;
    idle(1);
    per_en   = 1'b0;
    per_we   = '0;
  endtask

  task automatic read_reg(input logic [15:0] addr, output logic [15:0] data);
    per_addr = addr[14:1];
    per_we   = '0;
    per_en   = 1'b1;
    #20;                                              // Sample mid cycle once settled
    data     = per_dout;
    @(posedge mclk);
    #2;
    per_en   = 1'b0;
  endtask

  task automatic expect_value(input string what, input logic [15:0] got,
                              input logic [15:0] exp, input logic [15:0] mask);
    assert ((got & mask) === (exp & mask)) else
      report_fail($sformatf("** Error at %0t ns: %s is 0x%04h, expected 0x%04h mask 0x%04h",
                            $time, what, got, exp, mask));
  endtask

  task automatic compare_read(input logic [15:0] addr, input logic [15:0] exp,
                              input logic [15:0] mask, input string what);
    logic [15:0] got;
    read_reg(addr, got);
    expect_value(what, got, exp, mask);
  endtask

  task automatic expect_irq(input int idx, input logic lvl, input string what);
    assert (irq_bus[idx] === lvl) else
      report_fail($sformatf("** Error at %0t ns: irq_bus[%0d] is %b, expected %b (%s)",
                            $time, idx, irq_bus[idx], lvl, what));
  endtask

  task automatic wait_irq(input int idx, input int max_cyc, input string what);
    int n;
    n = 0;
    while (irq_bus[idx] !== 1'b1 && n < max_cyc) begin
      idle(1);
      n++;
    end
    assert (irq_bus[idx] === 1'b1) else
      report_fail($sformatf("Interrupt %s did not rise within %0d cycles", what, max_cyc));
  endtask

  // LED model follows writes to P2OUT and P2DIR
  task automatic track_leds(input logic [15:0] addr, input logic [1:0] we,
                            input logic [15:0] data);
    logic [15:0] out_a;
    logic [15:0] dir_a;
    logic        hit;
    out_a = port_reg(P2, per_bus_pkg::GPIO_OUT);
    dir_a = port_reg(P2, per_bus_pkg::GPIO_DIR);
    hit   = 1'b0;
    if (addr[15:1] == out_a[15:1] && we[out_a[0]]) begin
      led_out = out_a[0] ? data[15:8] : data[7:0];    // Odd byte on lane 1
      hit     = 1'b1;
    end
    if (addr[15:1] == dir_a[15:1] && we[dir_a[0]]) begin
      led_dir = dir_a[0] ? data[15:8] : data[7:0];
      hit     = 1'b1;
    end
    if (hit) expect_value("led", 16'(led), 16'(led_out[1:0] & led_dir[1:0]), 16'h0003);
  endtask

  // ====================
  // Stimulus table
  // ====================
  task automatic build_table();
    write_step(port_reg(P1, per_bus_pkg::GPIO_OUT), 2'b10, 16'hA500);
    write_step(port_reg(P1, per_bus_pkg::GPIO_DIR), 2'b01, 16'h005A);
    read_step(port_reg(P1, per_bus_pkg::GPIO_OUT), 16'hA500, 16'hFF00);
    read_step(port_reg(P1, per_bus_pkg::GPIO_DIR), 16'h005A, 16'h00FF);
    write_step(port_reg(P1, per_bus_pkg::GPIO_IES), 2'b01, 16'h00C3);
    write_step(port_reg(P1, per_bus_pkg::GPIO_IE), 2'b10, 16'h3C00);
    read_step(port_reg(P1, per_bus_pkg::GPIO_IES), 16'h3CC3, 16'hFFFF);  // Lanes independent
    write_step(port_reg(P1, per_bus_pkg::GPIO_SEL), 2'b01, 16'h0096);
    read_step(port_reg(P1, per_bus_pkg::GPIO_SEL), 16'h0096, 16'h00FF);
    write_step(port_reg(P2, per_bus_pkg::GPIO_OUT), 2'b10, 16'h0300);    // Still dark
    write_step(port_reg(P2, per_bus_pkg::GPIO_DIR), 2'b01, 16'h0001);
    read_step(port_reg(P2, per_bus_pkg::GPIO_OUT), 16'h0300, 16'hFF00);
    read_step(port_reg(P2, per_bus_pkg::GPIO_DIR), 16'h0001, 16'h00FF);
    write_step(port_reg(P2, per_bus_pkg::GPIO_DIR), 2'b01, 16'h0003);
    write_step(port_reg(P2, per_bus_pkg::GPIO_OUT), 2'b10, 16'h0200);
    write_step(port_reg(P2, per_bus_pkg::GPIO_IES), 2'b11, 16'h5AA5);    // IES and IE
    read_step(port_reg(P2, per_bus_pkg::GPIO_IES), 16'h5AA5, 16'hFFFF);
    write_step(port_reg(P2, per_bus_pkg::GPIO_SEL), 2'b01, 16'h00FF);
    read_step(port_reg(P2, per_bus_pkg::GPIO_SEL), 16'h00FF, 16'h00FF);
    write_step(per_bus_pkg::TA_TACCR0, 2'b11, 16'h1234);
    read_step(per_bus_pkg::TA_TACCR0, 16'h1234, 16'hFFFF);
    write_step(per_bus_pkg::TA_TACTL, 2'b11, 16'h02C6);   // SMCLK, /8, stopped, TACLR, TAIE
    read_step(per_bus_pkg::TA_TACTL, 16'h02C2, 16'hFFFF); // TACLR not stored
    write_step(per_bus_pkg::TA_TACTL, 2'b11, 16'h0000);
    read_step(per_bus_pkg::TA_TAR, 16'h0000, 16'hFFFF);
    write_step(per_bus_pkg::TA_TACCTL0, 2'b11, 16'h0010);
    read_step(per_bus_pkg::TA_TACCTL0, 16'h0010, 16'hFFFF);
    write_step(per_bus_pkg::TA_TACCTL0, 2'b11, 16'h0000);
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    logic [15:0] rd_data;
    logic [15:0] tar_a;
    logic [15:0] tar_b;
    logic [3:0]  sw_val;
    void'($urandom(84));                              // Seed once
    rst      = 1'b1;
    per_addr = '0;
    per_din  = '0;
    per_we   = '0;
    per_en   = 1'b0;
    aclk_en  = 1'b0;
    smclk_en = 1'b0;
    irq_acc  = '0;
    switch   = 4'h0;
    led_out  = '0;
    led_dir  = '0;
    cycle_cnt = 0;
    build_table();
    cycle_limit = steps.size() * 4 + 200;
    repeat (10) @(posedge mclk);
    #2;
    rst = 1'b0;

    foreach (steps[i]) begin
      if (steps[i].rd) begin
        read_reg(steps[i].addr, rd_data);
        expect_value($sformatf("table step %0d", i), rd_data, steps[i].exp, steps[i].mask);
      end else begin
        write_reg(steps[i].addr, steps[i].we, steps[i].data);
        track_leds(steps[i].addr, steps[i].we, steps[i].data);
      end
    end

    // Switches through the synchronizer
    write_reg(port_reg(P1, per_bus_pkg::GPIO_IES), 2'b11, 16'h0000);  // IES and IE off
    sw_val = 4'($urandom % 15) + 4'd1;                // Never the reset value
    switch = sw_val;
    idle(3);
    compare_read(port_reg(P1, per_bus_pkg::GPIO_IN), {12'h000, sw_val}, 16'h00FF, "P1IN");
    switch = 4'h0;
    idle(3);
    write_reg(port_reg(P1, per_bus_pkg::GPIO_IFG), 2'b10, 16'h0000);  // Flags from that edge

    // Port interrupts
    write_reg(port_reg(P1, per_bus_pkg::GPIO_IE), 2'b10, 16'h0100);
    expect_irq(irq_pkg::IRQ_PORT1, 1'b0, "port 1 idle");
    switch = 4'h1;                                    // Rising on pin 0
    wait_irq(irq_pkg::IRQ_PORT1, 5, "port 1 rising edge");
    compare_read(port_reg(P1, per_bus_pkg::GPIO_IFG), 16'h0100, 16'hFF00, "P1IFG rise");
    write_reg(port_reg(P1, per_bus_pkg::GPIO_IFG), 2'b10, 16'h0000);
    expect_irq(irq_pkg::IRQ_PORT1, 1'b0, "P1IFG cleared");
    switch = 4'h0;                                    // Falling edge ignored with IES 0
    idle(4);
    expect_irq(irq_pkg::IRQ_PORT1, 1'b0, "port 1 falling edge");
    compare_read(port_reg(P1, per_bus_pkg::GPIO_IFG), 16'h0000, 16'hFF00, "P1IFG fall");
    write_reg(port_reg(P2, per_bus_pkg::GPIO_IE), 2'b10, 16'h0200);
    write_reg(port_reg(P2, per_bus_pkg::GPIO_IFG), 2'b10, 16'h0200);  // Set by software
    expect_irq(irq_pkg::IRQ_PORT2, 1'b1, "P2IFG written");
    write_reg(port_reg(P2, per_bus_pkg::GPIO_IFG), 2'b10, 16'h0000);
    expect_irq(irq_pkg::IRQ_PORT2, 1'b0, "P2IFG cleared");

    // Timer up mode on SMCLK
    write_reg(per_bus_pkg::TA_TACCR0, 2'b11, 16'd20);
    write_reg(per_bus_pkg::TA_TACCTL0, 2'b11, 16'h0010);                // CCIE
    smclk_en = 1'b1;
    write_reg(per_bus_pkg::TA_TACTL, 2'b11, 16'h0216);  // SMCLK, /1, up, TACLR, TAIE
    wait_irq(irq_pkg::IRQ_TA0, 25, "TACCR0 compare");
    expect_irq(irq_pkg::IRQ_TA1, 1'b0, "TAIFG before wrap");
    compare_read(per_bus_pkg::TA_TAR, 16'd20, 16'hFFFF, "TAR at compare");
    irq_acc[irq_pkg::IRQ_TA0] = 1'b1;                 // Vector taken
    idle(1);
    irq_acc = '0;
    expect_irq(irq_pkg::IRQ_TA0, 1'b0, "CCIFG after accept");
    wait_irq(irq_pkg::IRQ_TA1, 25, "timer overflow");
    write_reg(per_bus_pkg::TA_TACTL, 2'b11, 16'h0212);  // Same mode with TAIFG low
    expect_irq(irq_pkg::IRQ_TA1, 1'b0, "TAIFG cleared by write");

    // Clock gating
    smclk_en = 1'b0;
    read_reg(per_bus_pkg::TA_TAR, tar_a);
    idle(30);
    read_reg(per_bus_pkg::TA_TAR, tar_b);
    expect_value("TAR with SMCLK gated", tar_b, tar_a, 16'hFFFF);
    write_reg(per_bus_pkg::TA_TACTL, 2'b11, 16'h0112);  // ACLK, up mode
    smclk_en = 1'b1;                                  // aclk_en stays low
    read_reg(per_bus_pkg::TA_TAR, tar_a);
    idle(30);
    read_reg(per_bus_pkg::TA_TAR, tar_b);
    expect_value("TAR with ACLK gated", tar_b, tar_a, 16'hFFFF);
    write_reg(per_bus_pkg::TA_TACTL, 2'b11, 16'h0004);  // Stop and clear
    smclk_en = 1'b0;

    if (uut.props_0.fail_cnt == 0) begin
      $display("No errors");
      $finish;
    end else begin
      report_fail($sformatf("Bound property checks failed %0d times", uut.props_0.fail_cnt));
    end
  end

endmodule

`default_nettype wire

// ==== all.f ====
design/per_bus_pkg.sv
design/irq_pkg.sv
design/gpio_port.sv
design/timer_a.sv
design/periph_core0.sv
verification/periph_core0_props.sv
verification/periph_core0_tb.sv
